//--- src.f
+incdir+include
+incdir+test
source/wb_pkg.sv
source/ex_wb_latch.sv
source/wb_stage.sv
source/gpr_file.sv
source/csr_file.sv
source/wb_top.sv
test/wb_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := wb_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/wb_tests.svh
task automatic check_all_state();
    for (int i = 0; i < 32; i++) begin
        @(negedge clk);
        check_rf(5'(i));
    end
    for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        check_csr(CSR_ADDRS[i]);
    end
endtask

// reset values, then lane 1 alone, first write aimed at r0
task automatic reset_and_single_writes();
    logic [`WB_REG_AW-1:0] dest;
    check_all_state();
    for (int i = 0; i < 8; i++) begin
        dest = (i == 0) ? 5'd0 : 5'($random(seed));
        @(negedge clk);
        drive_lane(1, 1'b1, 1'b1, 1'b1, dest, 1'b0, CSR_CRMD);
        drive_lane(2, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
        commit_bundle();
    end
endtask

task automatic dual_lane_ordering();
    logic [`WB_REG_AW-1:0] dest;
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        dest = rnd[4:0] | 5'd1;
        // same destination first, then two different ones
        @(negedge clk);
        drive_lane(1, 1'b1, 1'b1, 1'b1, dest, 1'b0, CSR_CRMD);
        drive_lane(2, 1'b1, 1'b1, 1'b1, dest, 1'b0, CSR_CRMD);
        commit_bundle();
        @(negedge clk);
        drive_lane(1, 1'b1, 1'b1, 1'b1, {1'b0, rnd[8:5]} | 5'd1, 1'b0, CSR_CRMD);
        drive_lane(2, 1'b1, 1'b1, 1'b1, {1'b1, rnd[8:5]}, 1'b0, CSR_CRMD);
        commit_bundle();
    end
endtask

// k=0 lane 1 uncommitted, k=1 lane 1 not issued,
// k=2 lane 2 uncommitted, k=3 lane 2 not issued
task automatic commit_qualification();
    logic [31:0] rnd;
    for (int k = 0; k < 4; k++) begin
        rnd = $random(seed);
        @(negedge clk);
        drive_lane(1, k != 1, k != 0, 1'b1, {1'b0, rnd[3:1], 1'b1}, 1'b0, CSR_CRMD);
        drive_lane(2, k != 3, k != 2, 1'b1, {1'b1, rnd[3:1], 1'b1}, 1'b0, CSR_CRMD);
        commit_bundle();
    end
endtask

task automatic csr_write_path();
    for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        drive_lane(1, 1'b1, 1'b1, 1'b0, '0, 1'b1, CSR_ADDRS[i]);
        drive_lane(2, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
        commit_bundle();
    end
    // both lanes ask, lane 1 owns the port
    @(negedge clk);
    drive_lane(1, 1'b1, 1'b1, 1'b0, '0, 1'b1, CSR_SAVE0);
    drive_lane(2, 1'b1, 1'b1, 1'b0, '0, 1'b1, CSR_SAVE1);
    commit_bundle();
    check_csr(CSR_SAVE1);
    @(negedge clk);
    drive_lane(1, 1'b1, 1'b1, 1'b0, '0, 1'b1, CSR_ECFG);
    drive_lane(2, 1'b1, 1'b1, 1'b0, '0, 1'b1, CSR_ECFG);
    commit_bundle();
    // unimplemented address
    @(negedge clk);
    drive_lane(1, 1'b1, 1'b1, 1'b0, '0, 1'b1, 14'h100);
    drive_lane(2, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
    commit_bundle();
    check_all_state();
endtask

task automatic back_pressure_stall();
    logic [`WB_REG_AW-1:0] dest;
    for (int b = 0; b < 2; b++) begin
        dest = 5'($random(seed)) | 5'd1;
        @(negedge clk);
        nblock1 = (b != 0);
        nblock2 = (b == 0);
        drive_lane(1, 1'b1, 1'b1, 1'b1, dest, 1'b0, CSR_CRMD);
        drive_lane(2, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
        repeat (3) begin
            @(negedge clk);
            check_value("ws_ready", 32'd0, 32'(ws_ready));
            check_value("retire1", 32'd0, 32'(retire1));
            check_value("fwd_valid1", 32'd0, 32'(fwd_valid1));
        end
        check_rf(dest);
        @(negedge clk);
        nblock1 = 1'b1;
        nblock2 = 1'b1;
        commit_bundle();
        // the cycle right after capture holds no second copy
        check_value("retire1", 32'd0, 32'(retire1));
    end
endtask

// random control bits, forwarding checked raw on every bundle
task automatic forwarding_random();
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        @(negedge clk);
        drive_lane(1, rnd[0], rnd[1], rnd[2], rnd[12:8], rnd[3], CSR_SAVE0);
        drive_lane(2, rnd[4], rnd[5], rnd[6], rnd[17:13], rnd[7], CSR_ERA);
        commit_bundle();
    end
endtask

//--- test/wb_tb.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module wb_tb
    import wb_pkg::*;
();

    localparam int READY_TIMEOUT = 20;

    // the six implemented csrs
    localparam logic [`WB_CSR_AW-1:0] CSR_ADDRS [6] = '{
        CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ERA, CSR_SAVE0, CSR_SAVE1
    };

    logic clk = 1'b0;
    logic arst_n;
    logic nblock1, nblock2, ws_ready;
    logic ex_issued1, ex_commit1, ex_gr_we1, ex_csr_we1;
    logic ex_issued2, ex_commit2, ex_gr_we2, ex_csr_we2;
    logic [`WB_REG_AW-1:0] ex_dest1, ex_dest2, rf_raddr1, rf_raddr2;
    logic [`WB_REG_AW-1:0] fwd_dest1, fwd_dest2;
    logic [`WB_CSR_AW-1:0] ex_csr_addr1, ex_csr_addr2, csr_raddr;
    logic [`WB_DATA_W-1:0] ex_result1, ex_pc1, ex_csr_wdata1;
    logic [`WB_DATA_W-1:0] ex_result2, ex_pc2, ex_csr_wdata2;
    logic fwd_valid1, fwd_we1, fwd_valid2, fwd_we2, retire1, retire2;
    logic [`WB_DATA_W-1:0] fwd_data1, fwd_data2, retire_pc1, retire_pc2;
    logic [`WB_DATA_W-1:0] rf_rdata1, rf_rdata2, csr_rdata;

    // scoreboard, indexed by register and by full csr address
    logic [`WB_DATA_W-1:0] gpr_exp [32];
    logic [`WB_DATA_W-1:0] csr_exp [1 << `WB_CSR_AW];
    logic [`WB_DATA_W-1:0] pc_next;
    integer seed = 32'had05;

    wb_top u_wb_top (.*);

    always #20 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("Fail at %0t: %s expected %h, got %h",
                                $time, name, exp, act));
        end
    endtask

    // writable bits per csr, zero for unimplemented addresses
    function automatic logic [31:0] csr_mask(logic [`WB_CSR_AW-1:0] addr);
        case (addr)
            CSR_CRMD: return 32'h0000_01ff;
            CSR_PRMD: return 32'h0000_0007;
            CSR_ECFG: return 32'h0000_1fff;
            CSR_ERA, CSR_SAVE0, CSR_SAVE1: return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic check_rf(logic [`WB_REG_AW-1:0] addr);
        rf_raddr1 = addr;
        rf_raddr2 = addr;
        #1;
        check_value($sformatf("rf_rdata1[%0d]", addr), gpr_exp[addr], rf_rdata1);
        check_value($sformatf("rf_rdata2[%0d]", addr), gpr_exp[addr], rf_rdata2);
    endtask

    task automatic check_csr(logic [`WB_CSR_AW-1:0] addr);
        csr_raddr = addr;
        #1;
        check_value($sformatf("csr_rdata[%h]", addr), csr_exp[addr], csr_rdata);
    endtask

    // called at a falling edge, payload is random
    task automatic drive_lane(int lane, logic issued, logic commit, logic gr_we,
                              logic [`WB_REG_AW-1:0] dest, logic csr_we,
                              logic [`WB_CSR_AW-1:0] csr_addr);
        logic [`WB_DATA_W-1:0] result;
        logic [`WB_DATA_W-1:0] csr_wdata;
        result = $random(seed);
        csr_wdata = $random(seed);
        pc_next = pc_next + 32'd4;
        if (lane == 1) begin
            ex_issued1    = issued;
            ex_commit1    = commit;
            ex_gr_we1     = gr_we;
            ex_dest1      = dest;
            ex_result1    = result;
            ex_pc1        = pc_next;
            ex_csr_we1    = csr_we;
            ex_csr_addr1  = csr_addr;
            ex_csr_wdata1 = csr_wdata;
        end else begin
            ex_issued2    = issued;
            ex_commit2    = commit;
            ex_gr_we2     = gr_we;
            ex_dest2      = dest;
            ex_result2    = result;
            ex_pc2        = pc_next;
            ex_csr_we2    = csr_we;
            ex_csr_addr2  = csr_addr;
            ex_csr_wdata2 = csr_wdata;
        end
    endtask

    task automatic clear_lanes();
        drive_lane(1, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
        drive_lane(2, 1'b0, 1'b0, 1'b0, '0, 1'b0, CSR_CRMD);
    endtask

    // returns right after the edge that captures the bundle
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!ws_ready) begin
            cycles++;
            if (cycles > READY_TIMEOUT) begin
                abort_run("timeout waiting for ws_ready to rise");
            end else begin
                @(posedge clk);
            end
        end
    endtask

    // capture the driven bundle, check retire and forward, then the writes
    task automatic commit_bundle();
        logic c1, c2, csr_wr;
        logic [`WB_REG_AW-1:0] d1, d2;
        logic [`WB_CSR_AW-1:0] csr_a;
        logic [`WB_DATA_W-1:0] csr_d;
        logic [`WB_DATA_W-1:0] m;
        c1 = ex_issued1 && ex_commit1;
        c2 = c1 && ex_issued2 && ex_commit2;
        d1 = ex_dest1;
        d2 = ex_dest2;
        csr_wr = ex_csr_we1 ? c1 : (c2 && ex_csr_we2);
        csr_a = ex_csr_we1 ? ex_csr_addr1 : ex_csr_addr2;
        csr_d = ex_csr_we1 ? ex_csr_wdata1 : ex_csr_wdata2;
        wait_ready();
        @(negedge clk);
        check_value("retire1", 32'(c1), 32'(retire1));
        check_value("retire2", 32'(c2), 32'(retire2));
        check_value("retire_pc1", ex_pc1, retire_pc1);
        check_value("retire_pc2", ex_pc2, retire_pc2);
        check_value("fwd_valid1", 32'(ex_issued1), 32'(fwd_valid1));
        check_value("fwd_we1", 32'(ex_gr_we1), 32'(fwd_we1));
        check_value("fwd_dest1", 32'(ex_dest1), 32'(fwd_dest1));
        check_value("fwd_data1", ex_result1, fwd_data1);
        check_value("fwd_valid2", 32'(ex_issued2), 32'(fwd_valid2));
        check_value("fwd_we2", 32'(ex_gr_we2), 32'(fwd_we2));
        check_value("fwd_dest2", 32'(ex_dest2), 32'(fwd_dest2));
        check_value("fwd_data2", ex_result2, fwd_data2);
        // program order, so lane 2 lands last on a shared destination
        if (c1 && ex_gr_we1 && (d1 != '0)) begin
            gpr_exp[d1] = ex_result1;
        end
        if (c2 && ex_gr_we2 && (d2 != '0)) begin
            gpr_exp[d2] = ex_result2;
        end
        if (csr_wr) begin
            m = csr_mask(csr_a);
            csr_exp[csr_a] = (csr_exp[csr_a] & ~m) | (csr_d & m);
        end
        clear_lanes();
        @(negedge clk);
        check_rf(d1);
        check_rf(d2);
        check_rf('0);
        check_csr(csr_a);
    endtask

    `include "wb_tests.svh"

    initial begin
        nblock1 = 1'b1;
        nblock2 = 1'b1;
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        csr_raddr = '0;
        pc_next = 32'h1c00_0000;
        clear_lanes();
        for (int i = 0; i < 32; i++) begin
            gpr_exp[i] = '0;
        end
        for (int i = 0; i < (1 << `WB_CSR_AW); i++) begin
            csr_exp[i] = '0;
        end
        csr_exp[CSR_CRMD] = 32'h0000_0008;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        reset_and_single_writes();
        dual_lane_ordering();
        commit_qualification();
        csr_write_path();
        back_pressure_stall();
        forwarding_random();
        $display("No errors");
        $finish;
    end

endmodule

//--- source/wb_top.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module wb_top
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ex_issued1,
    input  logic                  ex_commit1,
    input  logic                  ex_gr_we1,
    input  logic [`WB_REG_AW-1:0] ex_dest1,
    input  logic [`WB_DATA_W-1:0] ex_result1,
    input  logic [`WB_DATA_W-1:0] ex_pc1,
    input  logic                  ex_csr_we1,
    input  logic [`WB_CSR_AW-1:0] ex_csr_addr1,
    input  logic [`WB_DATA_W-1:0] ex_csr_wdata1,
    input  logic                  ex_issued2,
    input  logic                  ex_commit2,
    input  logic                  ex_gr_we2,
    input  logic [`WB_REG_AW-1:0] ex_dest2,
    input  logic [`WB_DATA_W-1:0] ex_result2,
    input  logic [`WB_DATA_W-1:0] ex_pc2,
    input  logic                  ex_csr_we2,
    input  logic [`WB_CSR_AW-1:0] ex_csr_addr2,
    input  logic [`WB_DATA_W-1:0] ex_csr_wdata2,
    input  logic                  nblock1,
    input  logic                  nblock2,
    output logic                  ws_ready,
    output logic                  fwd_valid1,
    output logic                  fwd_we1,
    output logic [`WB_REG_AW-1:0] fwd_dest1,
    output logic [`WB_DATA_W-1:0] fwd_data1,
    output logic                  fwd_valid2,
    output logic                  fwd_we2,
    output logic [`WB_REG_AW-1:0] fwd_dest2,
    output logic [`WB_DATA_W-1:0] fwd_data2,
    output logic                  retire1,
    output logic [`WB_DATA_W-1:0] retire_pc1,
    output logic                  retire2,
    output logic [`WB_DATA_W-1:0] retire_pc2,
    input  logic [`WB_REG_AW-1:0] rf_raddr1,
    output logic [`WB_DATA_W-1:0] rf_rdata1,
    input  logic [`WB_REG_AW-1:0] rf_raddr2,
    output logic [`WB_DATA_W-1:0] rf_rdata2,
    input  logic [`WB_CSR_AW-1:0] csr_raddr,
    output logic [`WB_DATA_W-1:0] csr_rdata
);

    // latched lane bundles
    logic                  ws_issued1;
    logic                  ws_commit1;
    logic                  ws_gr_we1;
    logic [`WB_REG_AW-1:0] ws_dest1;
    logic [`WB_DATA_W-1:0] ws_result1;
    logic [`WB_DATA_W-1:0] ws_pc1;
    logic                  ws_csr_we1;
    logic [`WB_CSR_AW-1:0] ws_csr_addr1;
    logic [`WB_DATA_W-1:0] ws_csr_wdata1;
    logic                  ws_issued2;
    logic                  ws_commit2;
    logic                  ws_gr_we2;
    logic [`WB_REG_AW-1:0] ws_dest2;
    logic [`WB_DATA_W-1:0] ws_result2;
    logic [`WB_DATA_W-1:0] ws_pc2;
    logic                  ws_csr_we2;
    logic [`WB_CSR_AW-1:0] ws_csr_addr2;
    logic [`WB_DATA_W-1:0] ws_csr_wdata2;

    // write ports into the storage
    logic                  rf_we1;
    logic [`WB_REG_AW-1:0] rf_waddr1;
    logic [`WB_DATA_W-1:0] rf_wdata1;
    logic                  rf_we2;
    logic [`WB_REG_AW-1:0] rf_waddr2;
    logic [`WB_DATA_W-1:0] rf_wdata2;
    logic                  csr_we;
    csr_addr_e             csr_addr;
    logic [`WB_DATA_W-1:0] csr_wdata;

    // names line up one to one with the ports here
    ex_wb_latch u_ex_wb_latch (.*);

    wb_stage u_wb_stage (.*);

    gpr_file u_gpr_file (
        .clk    (clk),
        .arst_n (arst_n),
        .we1    (rf_we1),
        .waddr1 (rf_waddr1),
        .wdata1 (rf_wdata1),
        .we2    (rf_we2),
        .waddr2 (rf_waddr2),
        .wdata2 (rf_wdata2),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2)
    );

    csr_file u_csr_file (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (csr_we),
        .waddr  (csr_addr),
        .wdata  (csr_wdata),
        .raddr  (csr_raddr),
        .rdata  (csr_rdata)
    );

endmodule

//--- source/csr_file.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module csr_file
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  csr_addr_e             waddr,
    input  logic [`WB_DATA_W-1:0] wdata,
    input  logic [`WB_CSR_AW-1:0] raddr,
    output logic [`WB_DATA_W-1:0] rdata
);

    localparam int NUM = `WB_CSR_NUM;

    // slot order for the tables below
    localparam csr_addr_e CSR_LIST [NUM] = '{
        CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ERA, CSR_SAVE0, CSR_SAVE1
    };

    // writable bits per slot
    localparam logic [`WB_DATA_W-1:0] WMASK [NUM] = '{
        32'h0000_01ff,
        32'h0000_0007,
        32'h0000_1fff,
        32'hffff_ffff,
        32'hffff_ffff,
        32'hffff_ffff
    };

    // crmd comes up with da set, rest clear
    localparam logic [`WB_DATA_W-1:0] RSTVAL [NUM] = '{
        32'h0000_0008,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000
    };

    logic [`WB_DATA_W-1:0] csr_q [NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM; i++) begin
                csr_q[i] <= RSTVAL[i];
            end
        end else if (we) begin
            for (int i = 0; i < NUM; i++) begin
                // bits outside the mask keep their old value
                if (waddr == CSR_LIST[i]) begin
                    csr_q[i] <= (csr_q[i] & ~WMASK[i]) | (wdata & WMASK[i]);
                end
            end
        end
    end

    // unmatched addresses fall through as zero
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM; i++) begin
            if (raddr == CSR_LIST[i]) begin
                rdata = csr_q[i];
            end
        end
    end

endmodule

//--- source/gpr_file.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module gpr_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we1,
    input  logic [`WB_REG_AW-1:0] waddr1,
    input  logic [`WB_DATA_W-1:0] wdata1,
    input  logic                  we2,
    input  logic [`WB_REG_AW-1:0] waddr2,
    input  logic [`WB_DATA_W-1:0] wdata2,
    input  logic [`WB_REG_AW-1:0] raddr1,
    output logic [`WB_DATA_W-1:0] rdata1,
    input  logic [`WB_REG_AW-1:0] raddr2,
    output logic [`WB_DATA_W-1:0] rdata2
);

    // r0 has no storage
    logic [`WB_DATA_W-1:0] regs [31:1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1 && (waddr1 != '0)) begin
                regs[waddr1] <= wdata1;
            end
            // port 2 last, so it wins a same-address collision
            if (we2 && (waddr2 != '0)) begin
                regs[waddr2] <= wdata2;
            end
        end
    end

    // no write-through, a write shows up after the edge
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    zero_reg_stays_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (we1 && (waddr1 == '0)) || (we2 && (waddr2 == '0))
        |=> ((raddr1 != '0) || (rdata1 == '0)) && ((raddr2 != '0) || (rdata2 == '0))
    ) else $error("write to r0 became visible");

endmodule

//--- source/wb_stage.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module wb_stage
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ws_issued1,
    input  logic                  ws_commit1,
    input  logic                  ws_gr_we1,
    input  logic [`WB_REG_AW-1:0] ws_dest1,
    input  logic [`WB_DATA_W-1:0] ws_result1,
    input  logic [`WB_DATA_W-1:0] ws_pc1,
    input  logic                  ws_csr_we1,
    input  logic [`WB_CSR_AW-1:0] ws_csr_addr1,
    input  logic [`WB_DATA_W-1:0] ws_csr_wdata1,
    input  logic                  ws_issued2,
    input  logic                  ws_commit2,
    input  logic                  ws_gr_we2,
    input  logic [`WB_REG_AW-1:0] ws_dest2,
    input  logic [`WB_DATA_W-1:0] ws_result2,
    input  logic [`WB_DATA_W-1:0] ws_pc2,
    input  logic                  ws_csr_we2,
    input  logic [`WB_CSR_AW-1:0] ws_csr_addr2,
    input  logic [`WB_DATA_W-1:0] ws_csr_wdata2,
    output logic                  rf_we1,
    output logic [`WB_REG_AW-1:0] rf_waddr1,
    output logic [`WB_DATA_W-1:0] rf_wdata1,
    output logic                  rf_we2,
    output logic [`WB_REG_AW-1:0] rf_waddr2,
    output logic [`WB_DATA_W-1:0] rf_wdata2,
    output logic                  csr_we,
    output csr_addr_e             csr_addr,
    output logic [`WB_DATA_W-1:0] csr_wdata,
    output logic                  fwd_valid1,
    output logic                  fwd_we1,
    output logic [`WB_REG_AW-1:0] fwd_dest1,
    output logic [`WB_DATA_W-1:0] fwd_data1,
    output logic                  fwd_valid2,
    output logic                  fwd_we2,
    output logic [`WB_REG_AW-1:0] fwd_dest2,
    output logic [`WB_DATA_W-1:0] fwd_data2,
    output logic                  retire1,
    output logic [`WB_DATA_W-1:0] retire_pc1,
    output logic                  retire2,
    output logic [`WB_DATA_W-1:0] retire_pc2
);

    logic     commit1;
    logic     commit2;
    logic     gr_wr1;
    logic     gr_wr2;
    logic     csr_wr1;
    logic     csr_wr2;
    wb_kind_e kind1;
    wb_kind_e kind2;

    function automatic logic writes_gpr(wb_kind_e k);
        return (k == WB_GPR) || (k == WB_BOTH);
    endfunction

    function automatic logic writes_csr(wb_kind_e k);
        return (k == WB_CSR) || (k == WB_BOTH);
    endfunction

    // in order: lane 2 may only retire behind lane 1
    assign commit1 = ws_issued1 && ws_commit1;
    assign commit2 = commit1 && ws_issued2 && ws_commit2;

    // younger lane wins on a shared destination
    assign gr_wr2 = commit2 && ws_gr_we2;
    assign gr_wr1 = commit1 && ws_gr_we1 && !(gr_wr2 && (ws_dest1 == ws_dest2));

    // single csr port, lane 1 owns it whenever it asks
    assign csr_wr1 = commit1 && ws_csr_we1;
    assign csr_wr2 = commit2 && ws_csr_we2 && !ws_csr_we1;

    assign kind1 = wb_kind_e'({csr_wr1, gr_wr1});
    assign kind2 = wb_kind_e'({csr_wr2, gr_wr2});

    assign rf_we1    = writes_gpr(kind1);
    assign rf_waddr1 = ws_dest1;
    assign rf_wdata1 = ws_result1;
    assign rf_we2    = writes_gpr(kind2);
    assign rf_waddr2 = ws_dest2;
    assign rf_wdata2 = ws_result2;

    // lane 1 request blocks lane 2 even if lane 1 itself is squashed
    assign csr_we    = writes_csr(kind1) || writes_csr(kind2);
    assign csr_addr  = csr_addr_e'(ws_csr_we1 ? ws_csr_addr1 : ws_csr_addr2);
    assign csr_wdata = ws_csr_we1 ? ws_csr_wdata1 : ws_csr_wdata2;

    // raw latched values, issue checks commit itself
    assign fwd_valid1 = ws_issued1;
    assign fwd_we1    = ws_gr_we1;
    assign fwd_dest1  = ws_dest1;
    assign fwd_data1  = ws_result1;
    assign fwd_valid2 = ws_issued2;
    assign fwd_we2    = ws_gr_we2;
    assign fwd_dest2  = ws_dest2;
    assign fwd_data2  = ws_result2;

    assign retire1    = commit1;
    assign retire_pc1 = ws_pc1;
    assign retire2    = commit2;
    assign retire_pc2 = ws_pc2;

    no_dual_same_dest: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(writes_gpr(kind1) && writes_gpr(kind2) && (rf_waddr1 == rf_waddr2))
    ) else $error("both gpr ports target the same register");

    retire_in_order: assert property (
        @(posedge clk) disable iff (!arst_n)
        retire2 |-> retire1
    ) else $error("lane 2 retired without lane 1");

endmodule

//--- source/ex_wb_latch.sv
`timescale 1ns/1ns
`include "wb_params.svh"

module ex_wb_latch
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  nblock1,
    input  logic                  nblock2,
    input  logic                  ex_issued1,
    input  logic                  ex_commit1,
    input  logic                  ex_gr_we1,
    input  logic [`WB_REG_AW-1:0] ex_dest1,
    input  logic [`WB_DATA_W-1:0] ex_result1,
    input  logic [`WB_DATA_W-1:0] ex_pc1,
    input  logic                  ex_csr_we1,
    input  logic [`WB_CSR_AW-1:0] ex_csr_addr1,
    input  logic [`WB_DATA_W-1:0] ex_csr_wdata1,
    input  logic                  ex_issued2,
    input  logic                  ex_commit2,
    input  logic                  ex_gr_we2,
    input  logic [`WB_REG_AW-1:0] ex_dest2,
    input  logic [`WB_DATA_W-1:0] ex_result2,
    input  logic [`WB_DATA_W-1:0] ex_pc2,
    input  logic                  ex_csr_we2,
    input  logic [`WB_CSR_AW-1:0] ex_csr_addr2,
    input  logic [`WB_DATA_W-1:0] ex_csr_wdata2,
    output logic                  ws_ready,
    output logic                  ws_issued1,
    output logic                  ws_commit1,
    output logic                  ws_gr_we1,
    output logic [`WB_REG_AW-1:0] ws_dest1,
    output logic [`WB_DATA_W-1:0] ws_result1,
    output logic [`WB_DATA_W-1:0] ws_pc1,
    output logic                  ws_csr_we1,
    output logic [`WB_CSR_AW-1:0] ws_csr_addr1,
    output logic [`WB_DATA_W-1:0] ws_csr_wdata1,
    output logic                  ws_issued2,
    output logic                  ws_commit2,
    output logic                  ws_gr_we2,
    output logic [`WB_REG_AW-1:0] ws_dest2,
    output logic [`WB_DATA_W-1:0] ws_result2,
    output logic [`WB_DATA_W-1:0] ws_pc2,
    output logic                  ws_csr_we2,
    output logic [`WB_CSR_AW-1:0] ws_csr_addr2,
    output logic [`WB_DATA_W-1:0] ws_csr_wdata2
);

    // execute may only advance when neither lane is mid multi-cycle op
    assign ws_ready = nblock1 && nblock2;

    // control bits, a bubble clears everything that could write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ws_issued1 <= 1'b0;
            ws_commit1 <= 1'b0;
            ws_issued2 <= 1'b0;
            ws_commit2 <= 1'b0;
            {ws_csr_we1, ws_gr_we1} <= WB_NONE;
            {ws_csr_we2, ws_gr_we2} <= WB_NONE;
        end else if (ws_ready) begin
            ws_issued1 <= ex_issued1;
            ws_commit1 <= ex_commit1;
            ws_gr_we1  <= ex_gr_we1;
            ws_csr_we1 <= ex_csr_we1;
            ws_issued2 <= ex_issued2;
            ws_commit2 <= ex_commit2;
            ws_gr_we2  <= ex_gr_we2;
            ws_csr_we2 <= ex_csr_we2;
        end else begin
            ws_issued1 <= 1'b0;
            ws_commit1 <= 1'b0;
            ws_issued2 <= 1'b0;
            ws_commit2 <= 1'b0;
            {ws_csr_we1, ws_gr_we1} <= WB_NONE;
            {ws_csr_we2, ws_gr_we2} <= WB_NONE;
        end
    end

    // payload only matters when issued is set
    always_ff @(posedge clk) begin
        if (ws_ready) begin
            ws_dest1      <= ex_dest1;
            ws_result1    <= ex_result1;
            ws_pc1        <= ex_pc1;
            ws_csr_addr1  <= ex_csr_addr1;
            ws_csr_wdata1 <= ex_csr_wdata1;
            ws_dest2      <= ex_dest2;
            ws_result2    <= ex_result2;
            ws_pc2        <= ex_pc2;
            ws_csr_addr2  <= ex_csr_addr2;
            ws_csr_wdata2 <= ex_csr_wdata2;
        end
    end

    // a stalled cycle must not leak an instruction into writeback
    bubble_on_block: assert property (
        @(posedge clk) disable iff (!arst_n)
        !ws_ready |=> !ws_issued1 && !ws_issued2
    ) else $error("latch captured a lane while ws_ready was low");

endmodule

//--- source/wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

    // implemented csr addresses, anything else reads zero
    typedef enum logic [`WB_CSR_AW-1:0] {
        CSR_CRMD  = 14'h000,
        CSR_PRMD  = 14'h001,
        CSR_ECFG  = 14'h004,
        CSR_ERA   = 14'h006,
        CSR_SAVE0 = 14'h030,
        CSR_SAVE1 = 14'h031
    } csr_addr_e;

    // what a lane really writes this cycle
    // bit 0 is the gpr write, bit 1 the csr write
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_GPR  = 2'b01,
        WB_CSR  = 2'b10,
        WB_BOTH = 2'b11
    } wb_kind_e;

endpackage

//--- include/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// datapath and pc width
`define WB_DATA_W 32

// general register address, 32 registers
`define WB_REG_AW 5

// csr address space width
`define WB_CSR_AW 14

// implemented csrs in csr_file
`define WB_CSR_NUM 6

`endif
